//--- gb_bus.f
+incdir+sim
src/gb_bus_pkg.sv
src/gb_cpu_bus_if.sv
src/gb_bus_fabric.sv
src/gb_irq_ctrl.sv
src/gb_work_ram.sv
src/gb_sys_regs.sv
src/gb_bus.sv
sim/tb_gb_bus.sv

//--- sim/tb_gb_bus_checks.svh
// included inside tb_gb_bus only; uses its signals, cur_row and is_cart, stops at the first error
`ifndef TB_GB_BUS_CHECKS_SVH
`define TB_GB_BUS_CHECKS_SVH

	// ------------------------------------------------------------------------
	// typed compares
	// ------------------------------------------------------------------------
	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h (row %0d)", name, got, exp, cur_row);
			fail_run();
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h (row %0d)", name, got, exp, cur_row);
			fail_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %h expected %h (row %0d)", name, got, exp, cur_row);
			fail_run();
		end
	endtask

	// cartridge and boot rom pins during the access cycle
	task automatic check_cart_pins(input addr_t a, input logic rd, input logic wr, input data_t d);
		check_bit("cart_rd", cart_rd, rd && is_cart(a));
		check_bit("cart_wr", cart_wr, wr && is_cart(a));
		if (is_cart(a)) begin
			check_addr("cart_addr", cart_addr, a);
			if (wr)
				check_data("cart_di", cart_di, d);
		end
		if (rd && a < 16'h0100)
			check_data("boot_addr", boot_addr, a[7:0]);
	endtask

	// idle outputs straight after reset
	task automatic check_reset_outputs();
		@(negedge clk_sys);
		check_bit("rd_valid", rd_valid, 1'b0);
		check_bit("cart_rd", cart_rd, 1'b0);
		check_bit("cart_wr", cart_wr, 1'b0);
		check_bit("irq_n", irq_n, 1'b1);
	endtask

	// read return sampled at the falling edge
	task automatic wait_rd_valid(output int late);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!rd_valid) begin
			n++;
			if (n >= RD_TIMEOUT) begin
				$display("read at row %0d got no rd_valid within %0d cycles", cur_row, n);
				fail_run();
			end
			@(negedge clk_sys);
		end
		late = n;                               // extra cycles past the first
	endtask

	task automatic fail_run();
		fail_count++;
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

`endif

//--- sim/tb_gb_bus.sv
// cart and boot rom answer from address patterns here; unwritten ram is never read back
`timescale 1ns/10ps

module tb_gb_bus;
	import gb_bus_pkg::*;

	typedef enum logic [3:0] {
		OP_WR, OP_WRR, OP_RD, OP_RDM, OP_JOY, OP_JOYF, OP_EV, OP_ACK, OP_IRQ, OP_RST
	} op_t;

	typedef struct packed {
		op_t        op;
		addr_t      addr;
		data_t      data;
		logic [1:0] mode;   // {fast_boot, is_gbc}
		data_t      exp;
	} row_t;

	localparam logic [1:0] M_MONO  = 2'b00;
	localparam logic [1:0] M_GBC   = 2'b01;
	localparam logic [1:0] M_FMONO = 2'b10;
	localparam logic [1:0] M_FAST  = 2'b11;
	localparam int         RD_TIMEOUT = 8;

	logic       clk_sys;
	logic       reset_ss;
	addr_t      cpu_addr;
	data_t      cpu_wdata;
	logic       cpu_wr;
	logic       cpu_rd;
	logic       int_ack;
	logic       is_gbc;
	logic       fast_boot;
	logic [3:0] irq_events;
	joy_t       joy_din;
	data_t      cart_do;
	data_t      boot_data;
	data_t      cpu_rdata;
	logic       rd_valid;
	logic       irq_n;
	data_t      irq_vector;
	logic [1:0] joy_p54;
	addr_t      cart_addr;
	logic       cart_rd;
	logic       cart_wr;
	data_t      cart_di;
	logic [7:0] boot_addr;

	// reference model state
	data_t      mem_model [int];   // wram by physical address, zp above 10000
	wram_bank_t bank_m;
	logic [1:0] p54_m;
	logic       boot_on_m;
	joy_t       joy_m;
	logic [15:0] lfsr_state;
	int         fail_count;
	int         cur_row;
	row_t       rows [$];

	`include "tb_gb_bus_checks.svh"

	gb_bus gb_bus_i (
		.clk_sys    (clk_sys),
		.reset_ss   (reset_ss),
		.cpu_addr   (cpu_addr),
		.cpu_wdata  (cpu_wdata),
		.cpu_wr     (cpu_wr),
		.cpu_rd     (cpu_rd),
		.int_ack    (int_ack),
		.is_gbc     (is_gbc),
		.fast_boot  (fast_boot),
		.irq_events (irq_events),
		.joy_din    (joy_din),
		.cart_do    (cart_do),
		.boot_data  (boot_data),
		.cpu_rdata  (cpu_rdata),
		.rd_valid   (rd_valid),
		.irq_n      (irq_n),
		.irq_vector (irq_vector),
		.joy_p54    (joy_p54),
		.cart_addr  (cart_addr),
		.cart_rd    (cart_rd),
		.cart_wr    (cart_wr),
		.cart_di    (cart_di),
		.boot_addr  (boot_addr)
	);

	always #20 clk_sys = ~clk_sys;   // 40 ns period

	// ------------------------------------------------------------------------
	// external devices answer one cycle behind their address
	// ------------------------------------------------------------------------
	function automatic data_t cart_byte(input addr_t a);
		return a[15:8] ^ {a[6:0], a[7]} ^ 8'ha5;
	endfunction

	function automatic data_t boot_byte(input logic [7:0] a);
		return {a[3:0], a[7:4]} ^ 8'h3c;
	endfunction

	always @(posedge clk_sys) begin
		boot_data <= boot_byte(boot_addr);
		cart_do   <= cart_byte(cart_addr);
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output data_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);   // one step per bit
			v = {v[6:0], lfsr_state[0]};
		end
	endtask

	// ------------------------------------------------------------------------
	// memory map model
	// ------------------------------------------------------------------------
	function automatic logic is_cart(input addr_t a);
		return !a[15] || a[15:13] == 3'b101;   // rom or cart ram
	endfunction

	function automatic int ram_key(input addr_t a, input logic gbc);
		wram_bank_t b;
		b = gbc ? bank_m : 3'd1;                // mono stuck at bank 1
		if (a >= 16'hff80)
			return 32'h10000 + int'(a);
		if (a[12])
			return int'(b) * 4096 + int'(a[11:0]);
		return int'(a[11:0]);                  // bank 0, echo too
	endfunction

	function automatic data_t model_read(input addr_t a, input logic gbc);
		if (!a[15])
			return (boot_on_m && a < 16'h0100) ? boot_byte(a[7:0]) : cart_byte(a);
		if (is_cart(a))
			return cart_byte(a);
		if (a == JOYP)
			return {2'b11, p54_m, joy_m};
		if (mem_model.exists(ram_key(a, gbc)))
			return mem_model[ram_key(a, gbc)];
		return OPEN_BUS;
	endfunction

	task automatic update_model(input addr_t a, input data_t d, input logic gbc);
		if (a == SVBK && gbc)
			bank_m = (d[2:0] == 3'd0) ? 3'd1 : d[2:0];
		else if (a == JOYP)
			p54_m = d[5:4];
		else if (a == BOOT && (gbc ? d == 8'h11 : d[0]))
			boot_on_m = 1'b0;
		else if ((a >= 16'hc000 && a < 16'hfe00) || (a >= 16'hff80 && a != IE))
			mem_model[ram_key(a, gbc)] = d;
	endtask

	task automatic reset_model();
		bank_m    = 3'd1;
		p54_m     = 2'b11;
		boot_on_m = 1'b1;
	endtask

	// ------------------------------------------------------------------------
	// bus accesses
	// ------------------------------------------------------------------------
	task automatic bus_write(input addr_t a, input data_t d, input logic [1:0] m);
		@(posedge clk_sys);
		cpu_addr  <= a;
		cpu_wdata <= d;
		cpu_wr    <= 1'b1;
		is_gbc    <= m[0];
		fast_boot <= m[1];
		@(negedge clk_sys);
		check_cart_pins(a, 1'b0, 1'b1, d);
		@(posedge clk_sys);                     // write lands here
		cpu_wr <= 1'b0;
		update_model(a, d, m[0]);
		if (a == JOYP) begin
			@(negedge clk_sys);
			check_data("joy_p54", {6'h00, joy_p54}, {6'h00, p54_m});
		end
	endtask

	task automatic bus_read(input addr_t a, input logic [1:0] m, output data_t got);
		int late;
		@(posedge clk_sys);
		cpu_addr  <= a;
		cpu_rd    <= 1'b1;
		is_gbc    <= m[0];
		fast_boot <= m[1];
		@(negedge clk_sys);
		check_cart_pins(a, 1'b1, 1'b0, 8'h00);
		@(posedge clk_sys);
		cpu_rd <= 1'b0;
		wait_rd_valid(late);
		got = cpu_rdata;
		if (late != 0) begin
			$display("read at row %0d returned %0d cycles late", cur_row, late);
			fail_run();
		end
		@(negedge clk_sys);
		check_bit("rd_valid", rd_valid, 1'b0);  // one cycle pulse
	endtask

	task automatic drive_joy(input joy_t j);
		@(posedge clk_sys);
		joy_din <= j;
		joy_m = j;
		repeat (3) @(posedge clk_sys);          // a fall reaches IF after two
	endtask

	task automatic apply_row(input row_t r);
		data_t v;
		data_t got;
		case (r.op)
			OP_WR:   bus_write(r.addr, r.data, r.mode);
			OP_WRR: begin
				take_bits(8, v);
				bus_write(r.addr, v, r.mode);
			end
			OP_RD: begin
				bus_read(r.addr, r.mode, got);
				check_data("cpu_rdata", got, r.exp);
			end
			OP_RDM: begin
				bus_read(r.addr, r.mode, got);
				check_data("cpu_rdata", got, model_read(r.addr, r.mode[0]));
			end
			OP_JOY: begin
				take_bits(4, v);
				drive_joy(v[3:0]);
			end
			OP_JOYF: drive_joy(r.data[3:0]);
			OP_EV: begin
				@(posedge clk_sys);
				irq_events <= r.data[3:0];
				repeat (2) @(posedge clk_sys);
			end
			OP_ACK: begin
				@(posedge clk_sys);
				int_ack <= 1'b1;
				@(posedge clk_sys);
				int_ack <= 1'b0;
				repeat (2) @(posedge clk_sys);  // clear lands after the fall
			end
			OP_IRQ: begin
				@(negedge clk_sys);
				check_bit("irq_n", irq_n, r.data[0]);
				check_data("irq_vector", irq_vector, r.exp);
			end
			default: begin                      // OP_RST
				@(posedge clk_sys);
				reset_ss <= 1'b1;
				repeat (10) @(posedge clk_sys);
				reset_ss <= 1'b0;
				reset_model();
				check_reset_outputs();
			end
		endcase
	endtask

	task automatic add_row(input op_t op, input addr_t a, input data_t d,
	                       input logic [1:0] m, input data_t e);
		rows.push_back('{op, a, d, m, e});
	endtask

	// ------------------------------------------------------------------------
	// stimulus table
	// ------------------------------------------------------------------------
	task automatic build_table();
		// power-up values
		add_row(OP_RD,  IE,       8'h00, M_GBC,  8'h00);
		add_row(OP_RD,  IF,       8'h00, M_GBC,  8'he0);
		add_row(OP_RDM, JOYP,     8'h00, M_GBC,  8'h00);
		add_row(OP_RD,  SVBK,     8'h00, M_GBC,  8'hf9);
		add_row(OP_RD,  SVBK,     8'h00, M_MONO, 8'hff);
		add_row(OP_RD,  16'hff03, 8'h00, M_GBC,  8'hff);   // unmapped
		// banking with bank 0 written as 00
		add_row(OP_WRR, 16'hc000, 8'h00, M_GBC,  8'h00);
		for (int k = 1; k < 8; k++) begin
			add_row(OP_WR,  SVBK,     (k == 1) ? 8'h00 : data_t'(k), M_GBC, 8'h00);
			add_row(OP_WRR, 16'hd000, 8'h00, M_GBC, 8'h00);
		end
		for (int k = 7; k > 0; k--) begin
			add_row(OP_WR,  SVBK,     (k == 1) ? 8'h00 : data_t'(k), M_GBC, 8'h00);
			add_row(OP_RDM, 16'hd000, 8'h00, M_GBC, 8'h00);
			add_row(OP_RDM, 16'hc000, 8'h00, M_GBC, 8'h00);   // bank 0 kept
		end
		add_row(OP_RDM, 16'he000, 8'h00, M_GBC,  8'h00);   // echo
		add_row(OP_RDM, 16'hf000, 8'h00, M_GBC,  8'h00);
		add_row(OP_WR,  SVBK,     8'h03, M_MONO, 8'h00);   // ignored in mono
		add_row(OP_RD,  SVBK,     8'h00, M_GBC,  8'hf9);
		add_row(OP_RDM, 16'hd000, 8'h00, M_MONO, 8'h00);
		// zero page and P1
		add_row(OP_WRR, 16'hff80, 8'h00, M_GBC,  8'h00);
		add_row(OP_WRR, 16'hfffe, 8'h00, M_GBC,  8'h00);
		add_row(OP_RDM, 16'hff80, 8'h00, M_GBC,  8'h00);
		add_row(OP_RDM, 16'hfffe, 8'h00, M_GBC,  8'h00);
		add_row(OP_RDM, 16'hc000, 8'h00, M_GBC,  8'h00);
		add_row(OP_WR,  JOYP,     8'h20, M_GBC,  8'h00);
		add_row(OP_JOY, JOYP,     8'h00, M_GBC,  8'h00);
		add_row(OP_RDM, JOYP,     8'h00, M_GBC,  8'h00);
		add_row(OP_WR,  JOYP,     8'h10, M_GBC,  8'h00);
		add_row(OP_JOY, JOYP,     8'h00, M_GBC,  8'h00);
		add_row(OP_RDM, JOYP,     8'h00, M_GBC,  8'h00);
		// interrupts where the data of OP_IRQ is the expected irq_n
		add_row(OP_WR,  IF,       8'h00, M_GBC,  8'h00);   // drop joypad leftovers
		add_row(OP_EV,  IF,       8'h05, M_GBC,  8'h00);
		add_row(OP_RD,  IF,       8'h00, M_GBC,  8'he5);
		add_row(OP_IRQ, IF,       8'h01, M_GBC,  8'h00);
		add_row(OP_WR,  IE,       8'h04, M_GBC,  8'h00);
		add_row(OP_IRQ, IF,       8'h00, M_GBC,  8'h50);
		add_row(OP_WR,  IE,       8'h1f, M_GBC,  8'h00);
		add_row(OP_EV,  IF,       8'h0f, M_GBC,  8'h00);
		add_row(OP_IRQ, IF,       8'h00, M_GBC,  8'h40);
		add_row(OP_ACK, IF,       8'h00, M_GBC,  8'h00);
		add_row(OP_IRQ, IF,       8'h00, M_GBC,  8'h48);
		add_row(OP_ACK, IF,       8'h00, M_GBC,  8'h00);
		add_row(OP_IRQ, IF,       8'h00, M_GBC,  8'h50);
		add_row(OP_ACK, IF,       8'h00, M_GBC,  8'h00);
		add_row(OP_IRQ, IF,       8'h00, M_GBC,  8'h58);
		add_row(OP_ACK, IF,       8'h00, M_GBC,  8'h00);
		add_row(OP_IRQ, IF,       8'h01, M_GBC,  8'h00);
		add_row(OP_EV,  IF,       8'h00, M_GBC,  8'h00);
		add_row(OP_JOYF, JOYP,    8'h0f, M_GBC,  8'h00);
		add_row(OP_JOYF, JOYP,    8'h0b, M_GBC,  8'h00);   // P12 falls
		add_row(OP_RD,  IF,       8'h00, M_GBC,  8'hf0);
		add_row(OP_IRQ, IF,       8'h00, M_GBC,  8'h60);
		add_row(OP_ACK, IF,       8'h00, M_GBC,  8'h00);
		add_row(OP_IRQ, IF,       8'h01, M_GBC,  8'h00);
		// boot overlay and cartridge
		add_row(OP_RDM, 16'h0000, 8'h00, M_FAST, 8'h00);
		add_row(OP_RDM, 16'h00ff, 8'h00, M_FAST, 8'h00);
		add_row(OP_RDM, 16'h0100, 8'h00, M_FAST, 8'h00);
		add_row(OP_RD,  BOOT,     8'h00, M_FAST, 8'h42);
		add_row(OP_WR,  BOOT,     8'h01, M_FAST, 8'h00);   // not enough in colour
		add_row(OP_RDM, 16'h0010, 8'h00, M_FAST, 8'h00);
		add_row(OP_WR,  BOOT,     8'h11, M_FAST, 8'h00);
		add_row(OP_RD,  BOOT,     8'h00, M_FAST, 8'hff);
		add_row(OP_RDM, 16'h0010, 8'h00, M_FAST, 8'h00);
		add_row(OP_WRR, 16'ha123, 8'h00, M_GBC,  8'h00);
		add_row(OP_RDM, 16'hbfff, 8'h00, M_GBC,  8'h00);
		add_row(OP_WR,  16'h2000, 8'h01, M_GBC,  8'h00);   // mbc style rom write
		add_row(OP_RST, 16'h0000, 8'h00, M_MONO, 8'h00);
		add_row(OP_RD,  BOOT,     8'h00, M_FMONO, 8'h42);
		add_row(OP_WR,  BOOT,     8'h02, M_MONO, 8'h00);   // even value keeps it mapped
		add_row(OP_RDM, 16'h0020, 8'h00, M_MONO, 8'h00);
		add_row(OP_WR,  BOOT,     8'h01, M_MONO, 8'h00);
		add_row(OP_RDM, 16'h0020, 8'h00, M_MONO, 8'h00);
	endtask

	initial begin
		clk_sys    = 1'b0;
		reset_ss   = 1'b1;
		cpu_addr   = '0;
		cpu_wdata  = '0;
		cpu_wr     = 1'b0;
		cpu_rd     = 1'b0;
		int_ack    = 1'b0;
		is_gbc     = 1'b1;
		fast_boot  = 1'b0;
		irq_events = 4'h0;
		joy_din    = 4'hf;                      // all buttons released
		cart_do    = '0;
		boot_data  = '0;
		joy_m      = 4'hf;
		lfsr_state = 16'd93;
		fail_count = 0;
		cur_row    = 0;
		reset_model();
		build_table();
		repeat (10) @(posedge clk_sys);
		reset_ss <= 1'b0;
		check_reset_outputs();
		for (int i = 0; i < rows.size(); i++) begin
			cur_row = i;
			apply_row(rows[i]);
		end
		@(posedge clk_sys);
		if (fail_count == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			fail_run();
		end
	end

endmodule

//--- src/gb_bus.sv
// cpu, cartridge and boot rom are external; no video, audio, timer or serial behind this bus
`timescale 1ns/10ps

module gb_bus (
	input  logic              clk_sys,
	input  logic              reset_ss,
	// cpu
	input  gb_bus_pkg::addr_t cpu_addr,
	input  gb_bus_pkg::data_t cpu_wdata,
	input  logic              cpu_wr,
	input  logic              cpu_rd,
	input  logic              int_ack,
	// mode
	input  logic              is_gbc,
	input  logic              fast_boot,
	// events
	input  logic [3:0]        irq_events,
	input  gb_bus_pkg::joy_t  joy_din,
	// external data
	input  gb_bus_pkg::data_t cart_do,
	input  gb_bus_pkg::data_t boot_data,
	// cpu return
	output gb_bus_pkg::data_t cpu_rdata,
	output logic              rd_valid,
	output logic              irq_n,
	output gb_bus_pkg::data_t irq_vector,
	output logic [1:0]        joy_p54,
	// cartridge / boot rom pins
	output gb_bus_pkg::addr_t cart_addr,
	output logic              cart_rd,
	output logic              cart_wr,
	output gb_bus_pkg::data_t cart_di,
	output logic [7:0]        boot_addr
);

	logic boot_active;  // from sys regs to the overlay decode

	gb_cpu_bus_if bus_if ();

	gb_bus_fabric fabric_i (
		.clk_sys     (clk_sys),
		.reset_ss    (reset_ss),
		.cpu_addr    (cpu_addr),
		.cpu_wdata   (cpu_wdata),
		.cpu_wr      (cpu_wr),
		.cpu_rd      (cpu_rd),
		.cpu_rdata   (cpu_rdata),
		.rd_valid    (rd_valid),
		.cart_addr   (cart_addr),
		.cart_rd     (cart_rd),
		.cart_wr     (cart_wr),
		.cart_di     (cart_di),
		.cart_do     (cart_do),
		.boot_data   (boot_data),
		.boot_active (boot_active),
		.boot_addr   (boot_addr),
		.bus         (bus_if.fabric)
	);

	gb_irq_ctrl irq_i (
		.clk_sys    (clk_sys),
		.reset_ss   (reset_ss),
		.bus        (bus_if.dev),
		.irq_events (irq_events),
		.joy_din    (joy_din),
		.int_ack    (int_ack),
		.irq_n      (irq_n),
		.irq_vector (irq_vector)
	);

	gb_work_ram ram_i (
		.clk_sys  (clk_sys),
		.reset_ss (reset_ss),
		.bus      (bus_if.dev),
		.is_gbc   (is_gbc)
	);

	gb_sys_regs sys_i (
		.clk_sys     (clk_sys),
		.reset_ss    (reset_ss),
		.bus         (bus_if.dev),
		.is_gbc      (is_gbc),
		.fast_boot   (fast_boot),
		.joy_din     (joy_din),
		.joy_p54     (joy_p54),
		.boot_active (boot_active)
	);

endmodule

//--- src/gb_sys_regs.sv
// P1 select and boot rom enable; once the boot rom is off only a reset brings it back
`timescale 1ns/10ps

module gb_sys_regs (
	input  logic             clk_sys,
	input  logic             reset_ss,
	gb_cpu_bus_if.dev        bus,
	input  logic             is_gbc,
	input  logic             fast_boot,
	input  gb_bus_pkg::joy_t joy_din,
	output logic [1:0]       joy_p54,
	output logic             boot_active
);
	import gb_bus_pkg::*;

	logic [1:0] p54;         // P15/P14 select
	logic       boot_off;    // this write unmaps the boot rom

	// ------------------------------------------------------------------------
	// joypad select
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			p54 <= P54_RESET;
		else if (bus.wr && bus.region == REG_JOYP)
			p54 <= bus.wdata[5:4];     // only the select bits are writable
	end

	assign joy_p54 = p54;

	// ------------------------------------------------------------------------
	// boot rom overlay
	// ------------------------------------------------------------------------
	// mono takes any odd value, colour needs exactly 11
	always_comb begin
		if (is_gbc)
			boot_off = (bus.wdata == BOOT_OFF_CGB);
		else
			boot_off = bus.wdata[0];
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss)
			boot_active <= 1'b1;
		else if (bus.wr && bus.region == REG_BOOT && boot_off)
			boot_active <= 1'b0;
	end

	// read back at the strobe edge
	always_ff @(posedge clk_sys) begin
		if (bus.rd) begin
			case (bus.region)
				REG_JOYP: bus.rdata_sys <= {2'b11, p54, joy_din};
				REG_BOOT: begin
					if (fast_boot && boot_active)
						bus.rdata_sys <= FAST_BOOT_FLAG;
					else
						bus.rdata_sys <= OPEN_BUS;
				end
				default:  bus.rdata_sys <= OPEN_BUS;
			endcase
		end
	end

endmodule

//--- src/gb_work_ram.sv
// 8 banks of 4k wram plus 127 byte zp ram; mono mode ignores SVBK and stays on bank 1
`timescale 1ns/10ps

module gb_work_ram (
	input  logic      clk_sys,
	input  logic      reset_ss,
	gb_cpu_bus_if.dev bus,
	input  logic      is_gbc
);
	import gb_bus_pkg::*;

	data_t      wram [0:32767];   // bank 0 at 0000, banks 1-7 above
	data_t      zpram [0:126];    // ff80-fffe
	wram_bank_t bank;             // SVBK contents
	wram_bank_t eff_bank;         // bank used for d000-dfff
	wram_addr_t wram_addr;
	logic [6:0] zp_addr;
	logic       wram_we;
	logic       zp_we;
	logic       svbk_we;

	// ------------------------------------------------------------------------
	// bank register
	// ------------------------------------------------------------------------
	assign svbk_we = bus.wr && bus.region == REG_SVBK && is_gbc;

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			bank <= BANK_RESET;
		end else if (svbk_we) begin
			if (bus.wdata[2:0] == 3'd0)
				bank <= 3'd1;             // bank 0 selects 1
			else
				bank <= bus.wdata[2:0];
		end
	end

	assign eff_bank = is_gbc ? bank : 3'd1; // mono ignores SVBK

	// ------------------------------------------------------------------------
	// address map
	// ------------------------------------------------------------------------
	// bit 12 splits the fixed and switchable halves for the echo too
	assign wram_addr = bus.addr[12] ? {eff_bank, bus.addr[11:0]}
	                                : {3'd0, bus.addr[11:0]};
	assign zp_addr   = bus.addr[6:0];   // ffff never decodes here

	assign wram_we = bus.wr && bus.region == REG_WRAM;
	assign zp_we   = bus.wr && bus.region == REG_ZPRAM;

	always_ff @(posedge clk_sys) begin
		if (wram_we)
			wram[wram_addr] <= bus.wdata;
	end

	always_ff @(posedge clk_sys) begin
		if (zp_we)
			zpram[zp_addr] <= bus.wdata;
	end

	// ------------------------------------------------------------------------
	// read port
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (bus.rd) begin
			case (bus.region)
				REG_WRAM:  bus.rdata_ram <= wram[wram_addr];
				REG_ZPRAM: bus.rdata_ram <= zpram[zp_addr];
				REG_SVBK: begin
					if (is_gbc)
						bus.rdata_ram <= {5'h1f, bank}; // upper bits read high
					else
						bus.rdata_ram <= OPEN_BUS;     // no SVBK on mono
				end
				default:   bus.rdata_ram <= OPEN_BUS;
			endcase
		end
	end

endmodule

//--- src/gb_irq_ctrl.sv
// runs on the rising edge at full clk_sys rate; event inputs are levels, a rise sets the IF bit
`timescale 1ns/10ps

module gb_irq_ctrl (
	input  logic              clk_sys,
	input  logic              reset_ss,
	gb_cpu_bus_if.dev         bus,
	input  logic [3:0]        irq_events, // vblank, lcd, timer, serial
	input  gb_bus_pkg::joy_t  joy_din,
	input  logic              int_ack,
	output logic              irq_n,
	output gb_bus_pkg::data_t irq_vector
);
	import gb_bus_pkg::*;

	irq_t       if_r;
	irq_t       ie_r;
	irq_t       if_next;
	logic [3:0] ev_prev;      // last event levels
	joy_t       joy_d1;       // joypad delay line
	joy_t       joy_d2;
	logic       ack_prev;
	irq_t       pending;
	irq_t       top_bit;      // one hot highest priority pending bit
	logic [3:0] ev_rise;
	logic       joy_fall;
	logic       ack_done;

	// ------------------------------------------------------------------------
	// priority and cpu interrupt line
	// ------------------------------------------------------------------------
	assign pending = if_r & ie_r;
	assign top_bit = pending & (~pending + irq_t'(1)); // lowest index = highest priority
	assign irq_n   = ~|pending;

	always_comb begin
		irq_vector = 8'h00;                  // nothing pending
		for (int i = 4; i >= 0; i--) begin
			if (pending[i])
				irq_vector = IRQ_VEC_BASE + data_t'(8 * i);
		end
	end

	// ------------------------------------------------------------------------
	// flag updates
	// ------------------------------------------------------------------------
	assign ev_rise  = irq_events & ~ev_prev;
	assign joy_fall = |(~joy_d1 & joy_d2);     // any P1x line went low
	assign ack_done = ack_prev && !int_ack;    // ack just ended

	always_comb begin
		if_next = if_r;
		if_next[3:0] = if_next[3:0] | ev_rise;
		if (joy_fall)
			if_next[4] = 1'b1;
		if (ack_done)
			if_next = if_next & ~top_bit;      // clear only the serviced source
		// cpu write wins over events in the same cycle
		if (bus.wr && bus.region == REG_IF)
			if_next = bus.wdata[4:0];
	end

	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			if_r     <= IF_RESET;
			ie_r     <= IE_RESET;
			ev_prev  <= 4'h0;
			joy_d1   <= 4'h0;
			joy_d2   <= 4'h0;
			ack_prev <= 1'b0;
		end else begin
			if_r     <= if_next;
			ev_prev  <= irq_events;
			joy_d1   <= joy_din;
			joy_d2   <= joy_d1;
			ack_prev <= int_ack;
			if (bus.wr && bus.region == REG_IE)
				ie_r <= bus.wdata[4:0];
		end
	end

	// register read back sampled at the strobe
	always_ff @(posedge clk_sys) begin
		if (bus.rd) begin
			case (bus.region)
				REG_IF:  bus.rdata_irq <= {3'b111, if_r};   // unused bits read high
				REG_IE:  bus.rdata_irq <= {3'b000, ie_r};
				default: bus.rdata_irq <= OPEN_BUS;
			endcase
		end
	end

endmodule

//--- src/gb_bus_fabric.sv
// read data comes one cycle after cpu_rd; cart and boot rom get no wait states
`timescale 1ns/10ps

module gb_bus_fabric (
	input  logic              clk_sys,
	input  logic              reset_ss,
	// cpu side
	input  gb_bus_pkg::addr_t cpu_addr,
	input  gb_bus_pkg::data_t cpu_wdata,
	input  logic              cpu_wr,
	input  logic              cpu_rd,
	output gb_bus_pkg::data_t cpu_rdata,
	output logic              rd_valid,
	// cartridge
	output gb_bus_pkg::addr_t cart_addr,
	output logic              cart_rd,
	output logic              cart_wr,
	output gb_bus_pkg::data_t cart_di,
	input  gb_bus_pkg::data_t cart_do,
	// boot rom
	input  gb_bus_pkg::data_t boot_data,
	input  logic              boot_active,
	output logic [7:0]        boot_addr,
	gb_cpu_bus_if.fabric      bus
);
	import gb_bus_pkg::*;

	region_t region;       // decode of the current access
	logic    boot_hit;     // rom read inside the 0000-00ff overlay
	logic    cart_sel;
	region_t rd_region;    // region of the read in flight
	logic    rd_boot;

	// ------------------------------------------------------------------------
	// address decode where the first match wins
	// ------------------------------------------------------------------------
	always_comb begin
		region = REG_NONE;
		if (!cpu_addr[15])
			region = REG_ROM;                          // 32k rom
		else if (cpu_addr[15:13] == 3'b101)
			region = REG_CRAM;                         // 8k cart ram
		else if (cpu_addr[15:14] == 2'b11 && cpu_addr[13:9] != 5'h1f)
			region = REG_WRAM;                         // c000-fdff with the echo
		else if (cpu_addr == JOYP)
			region = REG_JOYP;
		else if (cpu_addr == IF)
			region = REG_IF;
		else if (cpu_addr == BOOT)
			region = REG_BOOT;
		else if (cpu_addr == SVBK)
			region = REG_SVBK;
		else if (cpu_addr == IE)
			region = REG_IE;                           // must beat the zp check
		else if (cpu_addr[15:7] == 9'h1ff)
			region = REG_ZPRAM;
	end

	assign boot_hit = (region == REG_ROM) && (cpu_addr[14:8] == 7'h00) && boot_active;
	assign cart_sel = (region == REG_ROM) || (region == REG_CRAM);

	// access fields out to the blocks
	assign bus.addr   = cpu_addr;
	assign bus.wdata  = cpu_wdata;
	assign bus.wr     = cpu_wr;
	assign bus.rd     = cpu_rd;
	assign bus.region = region;

	// cartridge pins follow the strobe in the same cycle
	assign cart_addr = cpu_addr;
	assign cart_di   = cpu_wdata;
	assign cart_rd   = cpu_rd && cart_sel;
	assign cart_wr   = cpu_wr && cart_sel;
	assign boot_addr = cpu_addr[7:0];

	// ------------------------------------------------------------------------
	// read return one cycle behind the strobe
	// ------------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_ss) begin
			rd_valid  <= 1'b0;
			rd_region <= REG_NONE;
			rd_boot   <= 1'b0;
		end else begin
			rd_valid <= cpu_rd;
			if (cpu_rd) begin
				rd_region <= region;
				rd_boot   <= boot_hit;
			end
		end
	end

	always_comb begin
		case (rd_region)
			REG_ROM:                      cpu_rdata = rd_boot ? boot_data : cart_do;
			REG_CRAM:                     cpu_rdata = cart_do;
			REG_WRAM, REG_ZPRAM, REG_SVBK: cpu_rdata = bus.rdata_ram;
			REG_IF, REG_IE:               cpu_rdata = bus.rdata_irq;
			REG_JOYP, REG_BOOT:           cpu_rdata = bus.rdata_sys;
			default:                      cpu_rdata = OPEN_BUS;
		endcase
	end

endmodule

//--- src/gb_cpu_bus_if.sv
// one decoded cpu access per cycle; region comes only from the fabric, blocks never re-decode
`timescale 1ns/10ps

interface gb_cpu_bus_if;
	import gb_bus_pkg::*;

	addr_t   addr;
	data_t   wdata;
	logic    wr;        // one cycle write strobe
	logic    rd;        // one cycle read strobe
	region_t region;    // decoded in the access cycle

	// per block read data, sampled at the read strobe edge
	data_t   rdata_irq;
	data_t   rdata_ram;
	data_t   rdata_sys;

	modport fabric (
		output addr, wdata, wr, rd, region,
		input  rdata_irq, rdata_ram, rdata_sys
	);

	// each block drives only its own rdata member
	modport dev (
		input  addr, wdata, wr, rd, region,
		output rdata_irq, rdata_ram, rdata_sys
	);

endinterface

//--- src/gb_bus_pkg.sv
// widths, region codes and register map; other IO and OAM addresses decode to none
package gb_bus_pkg;

	// ------------------------------------------------------------------------
	// bus widths
	// ------------------------------------------------------------------------
	typedef logic [15:0] addr_t;      // cpu address
	typedef logic [7:0]  data_t;      // one bus byte
	typedef logic [4:0]  irq_t;       // vblank, lcd, timer, serial, joypad
	typedef logic [2:0]  wram_bank_t; // svbk bank, 1..7 in use
	typedef logic [14:0] wram_addr_t; // bank + 12 bit offset
	typedef logic [3:0]  joy_t;       // P10..P13 lines

	// decoded regions with one owner block each
	typedef enum logic [3:0] {
		REG_ROM,   // 0000-7fff cart rom with the boot overlay below 0100
		REG_CRAM,  // a000-bfff cart ram
		REG_WRAM,  // c000-dfff plus echo e000-fdff
		REG_ZPRAM, // ff80-fffe
		REG_JOYP,
		REG_IF,
		REG_IE,
		REG_BOOT,
		REG_SVBK,
		REG_NONE   // unmapped and reads open bus
	} region_t;

	// ------------------------------------------------------------------------
	// single address registers
	// ------------------------------------------------------------------------
	localparam addr_t JOYP = 16'hff00; // P1 select / joypad lines
	localparam addr_t IF   = 16'hff0f; // interrupt flags
	localparam addr_t BOOT = 16'hff50; // boot rom disable
	localparam addr_t SVBK = 16'hff70; // wram bank, colour only
	localparam addr_t IE   = 16'hffff; // interrupt enable

	// read constants
	localparam data_t OPEN_BUS       = 8'hff;
	localparam data_t FAST_BOOT_FLAG = 8'h42; // seen by the boot rom at ff50
	localparam data_t IRQ_VEC_BASE   = 8'h40; // vblank vector and +8 per step down
	localparam data_t BOOT_OFF_CGB   = 8'h11; // only value that unmaps the colour boot rom

	// reset values
	localparam irq_t       IE_RESET   = 5'h00;
	localparam irq_t       IF_RESET   = 5'h00;
	localparam logic [1:0] P54_RESET  = 2'b11; // both select lines idle
	localparam wram_bank_t BANK_RESET = 3'd1;

endpackage
